// File: src/dram_pkg.sv
// shared widths, access size and command encodings
// request, response and word command structs

package dram_pkg;

    typedef logic [31:0] byte_addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  byte_mask_t;   // one enable per byte lane

    // same encoding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    typedef enum logic [1:0] {
        CMD_READ    = 2'd0,
        CMD_WRITE   = 2'd1,
        CMD_REFRESH = 2'd2
    } cmd_kind_e;

    typedef struct packed {
        logic         is_store;
        access_size_e size;
        logic         is_unsigned;  // zero-extend on load
        byte_addr_t   addr;
        data_t        wdata;
    } mem_req_t;

    typedef struct packed {
        data_t rdata;
        logic  is_store;    // store ack, rdata unused
    } mem_rsp_t;

    typedef struct packed {
        cmd_kind_e  kind;
        byte_addr_t word_addr;  // low 2 bits zero
        data_t      wdata;
        byte_mask_t mask;
    } word_cmd_t;

endpackage

// File: src/mem_access_seq.sv
// load/store sequencer for byte addressed accesses on word memory
// splits unaligned accesses, merges and extends loads, schedules refresh

`timescale 1ns/100ps

module mem_access_seq #(
    parameter int REFRESH_ACCESSES = 16
) (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_req_valid,
    output logic               o_req_ready,
    input  dram_pkg::mem_req_t i_req,
    output logic               o_rsp_valid,
    input  logic               i_rsp_ready,
    output dram_pkg::mem_rsp_t o_rsp,
    input  logic               i_refresh_req,
    input  logic               i_init_done,
    output logic               o_cmd_valid,
    input  logic               i_cmd_ready,
    output dram_pkg::word_cmd_t o_cmd,
    input  logic               i_rd_valid,
    input  dram_pkg::data_t    i_rd_data
);
    import dram_pkg::*;

    localparam int CNT_W = $clog2(REFRESH_ACCESSES + 1);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_REFRESH,
        ST_FIRST,
        ST_WAIT1,
        ST_SECOND,
        ST_WAIT2,
        ST_RESP
    } state_e;

    state_e           state;
    logic [CNT_W-1:0] acc_cnt;     // requests since last refresh
    mem_req_t         req_q;
    data_t            rd_lo;
    data_t            rd_hi;

    logic       refresh_pending;
    logic [1:0] off;
    byte_mask_t size_mask;
    data_t      size_bits;
    data_t      wdata_sized;
    logic [7:0] mask8;          // lane mask over two words
    logic [63:0] wdata64;
    logic [63:0] rdata64;
    data_t      rdata_ext;
    logic       need_second;

    assign refresh_pending = (acc_cnt >= CNT_W'(REFRESH_ACCESSES)) || i_refresh_req;
    assign off             = req_q.addr[1:0];

    always_comb begin
        case (req_q.size)
            SIZE_BYTE: size_mask = 4'b0001;
            SIZE_HALF: size_mask = 4'b0011;
            default:   size_mask = 4'b1111;
        endcase
        for (int i = 0; i < 4; i++) begin
            size_bits[8*i +: 8] = {8{size_mask[i]}};
        end
    end

    assign wdata_sized = req_q.wdata & size_bits;
    assign mask8       = {4'b0000, size_mask} << off;
    assign wdata64     = {32'b0, wdata_sized} << {off, 3'b000};
    assign need_second = |mask8[7:4];  // access crosses into next word

    // merge both words, then extend per size
    assign rdata64 = {rd_hi, rd_lo} >> {off, 3'b000};

    always_comb begin
        case (req_q.size)
            SIZE_BYTE: rdata_ext = req_q.is_unsigned ? {24'b0, rdata64[7:0]}
                                                     : {{24{rdata64[7]}}, rdata64[7:0]};
            SIZE_HALF: rdata_ext = req_q.is_unsigned ? {16'b0, rdata64[15:0]}
                                                     : {{16{rdata64[15]}}, rdata64[15:0]};
            default:   rdata_ext = rdata64[31:0];
        endcase
    end

    // command port
    always_comb begin
        o_cmd_valid = (state == ST_REFRESH) || (state == ST_FIRST) || (state == ST_SECOND);
        o_cmd.kind  = req_q.is_store ? CMD_WRITE : CMD_READ;
        if (state == ST_REFRESH) begin
            o_cmd.kind = CMD_REFRESH;
        end
        if (state == ST_SECOND) begin
            o_cmd.word_addr = {req_q.addr[31:2], 2'b00} + 32'd4;
            o_cmd.wdata     = wdata64[63:32];
            o_cmd.mask      = mask8[7:4];
        end else begin
            o_cmd.word_addr = {req_q.addr[31:2], 2'b00};
            o_cmd.wdata     = wdata64[31:0];
            o_cmd.mask      = mask8[3:0];
        end
    end

    assign o_req_ready    = (state == ST_IDLE) && i_init_done && !refresh_pending;
    assign o_rsp_valid    = (state == ST_RESP);
    assign o_rsp.rdata    = req_q.is_store ? 32'b0 : rdata_ext;
    assign o_rsp.is_store = req_q.is_store;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state   <= ST_IDLE;
            acc_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_init_done) begin
                        if (refresh_pending) begin
                            state <= ST_REFRESH;    // refresh goes before next request
                        end else if (i_req_valid) begin
                            acc_cnt <= acc_cnt + 1'b1;
                            state   <= ST_FIRST;
                        end
                    end
                end
                ST_REFRESH: begin
                    if (i_cmd_ready) begin
                        acc_cnt <= '0;
                        state   <= ST_IDLE;
                    end
                end
                ST_FIRST: begin
                    if (i_cmd_ready) begin
                        if (!req_q.is_store) begin
                            state <= ST_WAIT1;
                        end else begin
                            state <= need_second ? ST_SECOND : ST_RESP;
                        end
                    end
                end
                ST_WAIT1: begin
                    if (i_rd_valid) begin
                        state <= need_second ? ST_SECOND : ST_RESP;
                    end
                end
                ST_SECOND: begin
                    if (i_cmd_ready) begin
                        state <= req_q.is_store ? ST_RESP : ST_WAIT2;
                    end
                end
                ST_WAIT2: begin
                    if (i_rd_valid) begin
                        state <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    if (i_rsp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request and read words
    always_ff @(posedge clk) begin
        if (o_req_ready && i_req_valid) begin
            req_q <= i_req;
        end
        if (state == ST_WAIT1 && i_rd_valid) begin
            rd_lo <= i_rd_data;
        end
        if (state == ST_WAIT2 && i_rd_valid) begin
            rd_hi <= i_rd_data;
        end
    end

endmodule

// File: src/word_mem_ctrl.sv
// word memory controller model
// init wait, access latency and refresh busy time, storage port driver

`timescale 1ns/100ps

module word_mem_ctrl #(
    parameter int MEM_AW         = 8,
    parameter int INIT_CYCLES    = 20,
    parameter int ACCESS_CYCLES  = 3,   // at least 3, covers RAM read latency
    parameter int REFRESH_CYCLES = 6
) (
    input  logic                clk,
    input  logic                i_reset,
    input  logic                i_cmd_valid,
    output logic                o_cmd_ready,
    input  dram_pkg::word_cmd_t i_cmd,
    output logic                o_rd_valid,
    output dram_pkg::data_t     o_rd_data,
    output logic                o_init_done,
    output logic                o_st_en,
    output logic                o_st_we,
    output logic [MEM_AW-1:0]   o_st_addr,
    output dram_pkg::data_t     o_st_wdata,
    output dram_pkg::byte_mask_t o_st_mask,
    input  dram_pkg::data_t     i_st_rdata
);
    import dram_pkg::*;

    localparam int CNT_W = $clog2(INIT_CYCLES + ACCESS_CYCLES + REFRESH_CYCLES + 1);

    typedef enum logic [1:0] {
        ST_INIT,
        ST_READY,
        ST_BUSY
    } state_e;

    state_e           state;
    logic [CNT_W-1:0] cnt;         // cycles left in current phase
    logic             op_read_q;   // busy period belongs to a read
    logic             accept;

    assign o_cmd_ready = (state == ST_READY);
    assign accept      = o_cmd_ready && i_cmd_valid;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state       <= ST_INIT;
            cnt         <= CNT_W'(INIT_CYCLES - 1);
            o_init_done <= 1'b0;
            op_read_q   <= 1'b0;
            o_rd_valid  <= 1'b0;
            o_st_en     <= 1'b0;
            o_st_we     <= 1'b0;
        end else begin
            o_rd_valid <= 1'b0;
            o_st_en    <= 1'b0;
            o_st_we    <= 1'b0;
            case (state)
                ST_INIT: begin
                    if (cnt == '0) begin
                        o_init_done <= 1'b1;
                        state       <= ST_READY;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                ST_READY: begin
                    if (accept) begin
                        state     <= ST_BUSY;
                        op_read_q <= (i_cmd.kind == CMD_READ);
                        if (i_cmd.kind == CMD_REFRESH) begin
                            cnt <= CNT_W'(REFRESH_CYCLES - 1);  // no storage access
                        end else begin
                            cnt     <= CNT_W'(ACCESS_CYCLES - 1);
                            o_st_en <= 1'b1;
                            o_st_we <= (i_cmd.kind == CMD_WRITE);
                        end
                    end
                end
                ST_BUSY: begin
                    // read data is out of the RAM by now
                    if (cnt == CNT_W'(1) && op_read_q) begin
                        o_rd_valid <= 1'b1;
                    end
                    if (cnt == '0) begin
                        state <= ST_READY;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= ST_INIT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_st_addr  <= i_cmd.word_addr[MEM_AW+1:2];
            o_st_wdata <= i_cmd.wdata;
            o_st_mask  <= i_cmd.mask;
        end
        if (state == ST_BUSY && cnt == CNT_W'(1) && op_read_q) begin
            o_rd_data <= i_st_rdata;
        end
    end

endmodule

// File: src/word_store.sv
// byte-lane masked word RAM, one synchronous port

`timescale 1ns/100ps

module word_store #(
    parameter int MEM_AW = 8
) (
    input  logic                 clk,
    input  logic                 i_en,
    input  logic                 i_we,
    input  logic [MEM_AW-1:0]    i_addr,
    input  dram_pkg::data_t      i_wdata,
    input  dram_pkg::byte_mask_t i_mask,
    output dram_pkg::data_t      o_rdata
);
    import dram_pkg::*;

    data_t mem [2**MEM_AW];

    always_ff @(posedge clk) begin
        if (i_en) begin
            if (i_we) begin
                for (int i = 0; i < 4; i++) begin
                    if (i_mask[i]) begin
                        mem[i_addr][8*i +: 8] <= i_wdata[8*i +: 8];
                    end
                end
            end
            o_rdata <= mem[i_addr];    // old data on write
        end
    end

endmodule

// File: src/dram_subsys.sv
// memory subsystem top level
// sequencer, word controller and word storage

`timescale 1ns/100ps

module dram_subsys #(
    parameter int MEM_AW           = 8,
    parameter int INIT_CYCLES      = 20,
    parameter int ACCESS_CYCLES    = 3,
    parameter int REFRESH_CYCLES   = 6,
    parameter int REFRESH_ACCESSES = 16
) (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_req_valid,
    output logic               o_req_ready,
    input  dram_pkg::mem_req_t i_req,
    output logic               o_rsp_valid,
    input  logic               i_rsp_ready,
    output dram_pkg::mem_rsp_t o_rsp,
    input  logic               i_refresh_req,
    output logic               o_init_done
);
    import dram_pkg::*;

    logic              cmd_valid;
    logic              cmd_ready;
    word_cmd_t         cmd;
    logic              rd_valid;
    data_t             rd_data;
    logic              st_en;
    logic              st_we;
    logic [MEM_AW-1:0] st_addr;
    data_t             st_wdata;
    byte_mask_t        st_mask;
    data_t             st_rdata;

    mem_access_seq #(
        .REFRESH_ACCESSES(REFRESH_ACCESSES)
    ) u_seq (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_req_valid  (i_req_valid),
        .o_req_ready  (o_req_ready),
        .i_req        (i_req),
        .o_rsp_valid  (o_rsp_valid),
        .i_rsp_ready  (i_rsp_ready),
        .o_rsp        (o_rsp),
        .i_refresh_req(i_refresh_req),
        .i_init_done  (o_init_done),
        .o_cmd_valid  (cmd_valid),
        .i_cmd_ready  (cmd_ready),
        .o_cmd        (cmd),
        .i_rd_valid   (rd_valid),
        .i_rd_data    (rd_data)
    );

    word_mem_ctrl #(
        .MEM_AW        (MEM_AW),
        .INIT_CYCLES   (INIT_CYCLES),
        .ACCESS_CYCLES (ACCESS_CYCLES),
        .REFRESH_CYCLES(REFRESH_CYCLES)
    ) u_ctrl (
        .clk        (clk),
        .i_reset    (i_reset),
        .i_cmd_valid(cmd_valid),
        .o_cmd_ready(cmd_ready),
        .i_cmd      (cmd),
        .o_rd_valid (rd_valid),
        .o_rd_data  (rd_data),
        .o_init_done(o_init_done),
        .o_st_en    (st_en),
        .o_st_we    (st_we),
        .o_st_addr  (st_addr),
        .o_st_wdata (st_wdata),
        .o_st_mask  (st_mask),
        .i_st_rdata (st_rdata)
    );

    word_store #(
        .MEM_AW(MEM_AW)
    ) u_store (
        .clk    (clk),
        .i_en   (st_en),
        .i_we   (st_we),
        .i_addr (st_addr),
        .i_wdata(st_wdata),
        .i_mask (st_mask),
        .o_rdata(st_rdata)
    );

endmodule

// File: tests/tb_clock.sv
// testbench clock, 4 ns period, and a 2-cycle reset

`timescale 1ns/100ps

module tb_clock (
    output logic clk,
    output logic o_reset
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        o_reset = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        o_reset = 1'b0;     // released between edges
    end

endmodule

// File: tests/tb_dram_subsys.sv
// directed tests for the memory subsystem
// byte reference memory, lcg stimulus, check task and summary

`timescale 1ns/100ps

module tb_dram_subsys;
    import dram_pkg::*;

    localparam int REFRESH_ACCESSES = 16;
    localparam int WAIT_LIMIT       = 200;   // cycles per wait loop

    logic     clk;
    logic     i_reset;
    logic     i_req_valid;
    logic     o_req_ready;
    mem_req_t i_req;
    logic     o_rsp_valid;
    logic     i_rsp_ready;
    mem_rsp_t o_rsp;
    logic     i_refresh_req;
    logic     o_init_done;

    logic [7:0]  ref_mem [1024];
    logic [31:0] lcg_state;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_err_start;
    logic        timed_out;     // set once a wait runs out
    data_t       rsp_data;      // last response seen
    logic        rsp_store;

    tb_clock u_clock (
        .clk    (clk),
        .o_reset(i_reset)
    );

    dram_subsys #(
        .REFRESH_ACCESSES(REFRESH_ACCESSES)
    ) i_dut (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_req_valid  (i_req_valid),
        .o_req_ready  (o_req_ready),
        .i_req        (i_req),
        .o_rsp_valid  (o_rsp_valid),
        .i_rsp_ready  (i_rsp_ready),
        .o_rsp        (o_rsp),
        .i_refresh_req(i_refresh_req),
        .o_init_done  (o_init_done)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int size_bytes(int size);
        return (size == 0) ? 1 : (size == 1) ? 2 : 4;
    endfunction

    // little endian bytes, then zero or sign extension
    function automatic data_t expected_load(int addr, int size, logic is_uns);
        data_t      value;
        logic [9:0] idx;
        logic       sign;
        int         n;
        n     = size_bytes(size);
        value = '0;
        for (int k = 0; k < n; k++) begin
            idx              = 10'(addr + k);
            value[8*k +: 8]  = ref_mem[idx];
        end
        sign = (n == 1) ? value[7] : (n == 2) ? value[15] : value[31];
        if (!is_uns && sign) begin
            for (int k = n; k < 4; k++) begin
                value[8*k +: 8] = 8'hff;
            end
        end
        return value;
    endfunction

    task automatic ref_store(int addr, int size, data_t wdata);
        logic [9:0] idx;
        for (int k = 0; k < size_bytes(size); k++) begin
            idx          = 10'(addr + k);
            ref_mem[idx] = wdata[8*k +: 8];
        end
    endtask

    task automatic check(string name, data_t expected, data_t actual);
        if (expected !== actual) begin
            $display("MISMATCH at %0t: %s expected %h actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic report_timeout(string what);
        $display("timeout at %0t: %s", $time, what);
        timed_out = 1'b1;
        errors++;
    endtask

    // called just after a falling edge, returns once the response is seen
    task automatic send_access(logic is_store, int size, logic is_uns, int addr, data_t wdata);
        int n;
        if (timed_out) begin
            return;
        end
        i_req.is_store    = is_store;
        i_req.size        = access_size_e'(size[1:0]);
        i_req.is_unsigned = is_uns;
        i_req.addr        = addr;
        i_req.wdata       = wdata;
        i_req_valid       = 1'b1;
        n = 0;
        while (!o_req_ready && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!o_req_ready) begin
            i_req_valid = 1'b0;
            report_timeout($sformatf("request to %h was never accepted", addr));
            return;
        end
        @(negedge clk);
        i_req_valid = 1'b0;
        n = 0;
        while (!o_rsp_valid && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!o_rsp_valid) begin
            report_timeout($sformatf("no response for access to %h", addr));
            return;
        end
        rsp_data  = o_rsp.rdata;
        rsp_store = o_rsp.is_store;
        if (i_rsp_ready) begin
            @(negedge clk);
            check("o_rsp_valid after handshake", 32'd0, 32'(o_rsp_valid));
        end
    endtask

    task automatic store_access(int size, int addr, data_t wdata);
        send_access(1'b1, size, 1'b0, addr, wdata);
        ref_store(addr, size, wdata);
        if (!timed_out) begin
            check("o_rsp.is_store", 32'd1, 32'(rsp_store));
        end
    endtask

    task automatic load_check(int size, logic is_uns, int addr);
        send_access(1'b0, size, is_uns, addr, '0);
        if (!timed_out) begin
            check("o_rsp.is_store", 32'd0, 32'(rsp_store));
            check($sformatf("o_rsp.rdata at %h", addr), expected_load(addr, size, is_uns),
                  rsp_data);
        end
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (errors != test_err_start) begin
            tests_failed++;
            $display("test %s: fail", name);
        end else begin
            $display("test %s: pass", name);
        end
        test_err_start = errors;
    endtask

    task automatic test_init();
        int n;
        n = 0;
        while (!o_init_done && n < WAIT_LIMIT) begin
            check("o_req_ready before init", 32'd0, 32'(o_req_ready));
            check("o_rsp_valid before init", 32'd0, 32'(o_rsp_valid));
            @(negedge clk);
            n++;
        end
        if (!o_init_done) begin
            report_timeout("o_init_done never rose");
        end else begin
            check("o_req_ready after init", 32'd1, 32'(o_req_ready));
        end
        end_test("init");
    endtask

    task automatic test_aligned();
        data_t byte_vals [4];
        byte_vals = '{32'h81, 32'h7f, 32'hfff0, 32'h05};    // upper bits must be ignored
        store_access(2, 'h000, 32'hdeadbeef);
        load_check(2, 1'b0, 'h000);
        store_access(1, 'h004, 32'hffff8a5c);
        store_access(1, 'h006, 32'h00001234);
        load_check(1, 1'b0, 'h004);
        load_check(1, 1'b1, 'h004);
        load_check(1, 1'b0, 'h006);
        load_check(2, 1'b0, 'h004);
        for (int k = 0; k < 4; k++) begin
            store_access(0, 'h008 + k, byte_vals[k]);
        end
        for (int k = 0; k < 4; k++) begin
            load_check(0, 1'b0, 'h008 + k);
            load_check(0, 1'b1, 'h008 + k);
        end
        end_test("aligned");
    endtask

    task automatic test_unaligned();
        for (int w = 0; w < 8; w++) begin
            store_access(2, 'h040 + 4 * w, lcg_next());
        end
        store_access(1, 'h041, lcg_next());
        store_access(1, 'h046, lcg_next());
        store_access(1, 'h04b, lcg_next());     // half crossing at offset 3
        store_access(0, 'h045, lcg_next());
        store_access(0, 'h04e, lcg_next());
        store_access(2, 'h051, lcg_next());
        store_access(2, 'h056, lcg_next());
        store_access(2, 'h05b, lcg_next());
        for (int a = 'h040; a < 'h060; a++) begin
            load_check(0, 1'b1, a);
        end
        end_test("unaligned stores");
    endtask

    task automatic test_random_loads();
        int    addr;
        data_t draw;
        for (int w = 0; w < 32; w++) begin
            store_access(2, 'h200 + 4 * w, lcg_next());
        end
        for (int i = 0; i < 40; i++) begin
            addr = 'h200 + int'(lcg_next() % 32'd124);
            store_access(i % 3, addr, lcg_next());
            addr = 'h200 + 4 * int'(lcg_next() % 32'd31) + (i % 4);
            draw = lcg_next();
            load_check((i / 4) % 3, draw[31], addr);
        end
        end_test("random loads");
    endtask

    task automatic test_backpressure();
        mem_rsp_t held;
        store_access(2, 'h300, lcg_next());
        store_access(2, 'h304, lcg_next());
        i_rsp_ready = 1'b0;
        send_access(1'b0, 2, 1'b0, 'h302, '0);
        if (!timed_out) begin
            held = o_rsp;
            check("o_rsp.rdata under back-pressure", expected_load('h302, 2, 1'b0), held.rdata);
            repeat (6) begin
                @(negedge clk);
                check("o_rsp_valid while stalled", 32'd1, 32'(o_rsp_valid));
                check("o_rsp.rdata while stalled", held.rdata, o_rsp.rdata);
                check("o_req_ready while stalled", 32'd0, 32'(o_req_ready));
            end
            i_rsp_ready = 1'b1;
            @(negedge clk);
            check("o_rsp_valid after release", 32'd0, 32'(o_rsp_valid));
            @(negedge clk);
            check("o_rsp_valid one cycle later", 32'd0, 32'(o_rsp_valid));
        end
        i_rsp_ready = 1'b1;
        end_test("back-pressure");
    endtask

    task automatic test_refresh();
        for (int w = 0; w < 4; w++) begin
            store_access(2, 'h380 + 4 * w, lcg_next());
        end
        i_refresh_req = 1'b1;   // one cycle pulse while idle
        @(negedge clk);
        i_refresh_req = 1'b0;
        check("o_req_ready during refresh", 32'd0, 32'(o_req_ready));
        for (int w = 0; w < 4; w++) begin
            load_check(2, 1'b0, 'h380 + 4 * w);
        end
        load_check(2, 1'b0, 'h383);
        for (int i = 0; i < 2 * REFRESH_ACCESSES + 2; i++) begin
            if (i % 2 == 0) begin
                store_access(0, 'h390 + i, lcg_next());
            end else begin
                load_check(1, 1'b0, 'h380 + (i % 15));
            end
        end
        for (int a = 'h390; a < 'h390 + 2 * REFRESH_ACCESSES + 2; a += 2) begin
            load_check(0, 1'b1, a);
        end
        end_test("refresh");
    endtask

    initial begin
        int n;
        i_req_valid    = 1'b0;
        i_req          = '0;
        i_rsp_ready    = 1'b1;
        i_refresh_req  = 1'b0;
        lcg_state      = 32'd99075;
        errors         = 0;
        tests_run      = 0;
        tests_failed   = 0;
        test_err_start = 0;
        timed_out      = 1'b0;
        n = 0;
        @(posedge clk);
        while (i_reset && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (i_reset) begin
            report_timeout("reset was never released");
        end
        test_init();
        test_aligned();
        test_unaligned();
        test_random_loads();
        test_backpressure();
        test_refresh();
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: vlog.f
src/dram_pkg.sv
src/mem_access_seq.sv
src/word_mem_ctrl.sv
src/word_store.sv
src/dram_subsys.sv
tests/tb_clock.sv
tests/tb_dram_subsys.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log
set -e

rm -rf obj_dir sim.log
verilator --binary --timing -j 0 --top-module tb_dram_subsys -f vlog.f -o sim_tb
./obj_dir/sim_tb | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
